// File: sim/psg_trace.hex
// kind[31:28] count[27:16] data[15:0]; kind 0 command, 1 exact last sample
// (data[8] sign, [7:0] magnitude), 2 magnitude on all (data[12] both signs), f end
10030000 // idle after reset
20040000
00002000 // v0 period 0
00004009 // v0 volume 9
00006000 // v0 gate on
10030009
00002800 // v1 period 0
00004803 // v1 volume 3
00006800 // v1 gate on
00003000 // v2 period 0
00005005 // v2 volume 5
00007000 // v2 gate on
10030011 // 9 + 3 + 5
20040011
00003800 // v3 period 0
0000580F // v3 volume 15
00007800 // v3 gate on
10030020 // 9 + 3 + 5 + 15
00008800 // v1 gate off
1003001D
0000A000 // reset all
10030000
20040000
00003000 // v2 period 0
00005007 // v2 volume 7
00007000 // v2 gate on
10030007
0000300F // v2 period 15, half wave 64 clocks
20101007 // +-7, both signs
00009000 // v2 gate off
10030000
F0000000

// File: all.f
+incdir+verilog
verilog/psg_pkg.sv
verilog/psg_voice_if.sv
verilog/psg_cmd_decoder.sv
verilog/psg_voice.sv
verilog/psg_mixer.sv
verilog/psg_top.sv
sim/psg_assertions.sv
sim/psg_tb.sv

// File: Makefile
TOP := psg_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal \
	  -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: sim/psg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module psg_tb;

  localparam int TRACE_DEPTH    = 64;
  localparam int CMD_TIMEOUT    = 100;   // clocks
  localparam int SAMPLE_TIMEOUT = 1000;  // clocks, one sample is due every 64

  logic        CLK = 1'b0;
  logic        arst_n;
  logic        cmd_valid;
  logic        cmd_ready;
  logic [15:0] cmd_data;
  logic        pcm_valid;
  logic        pcm_ready = 1'b0;
  logic        pcm_neg;
  logic [7:0]  pcm_out;

  logic [31:0] trace_mem [TRACE_DEPTH];  // kind, count, data
  integer      seed = 79466;

  psg_top dut_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_ready (cmd_ready),
    .cmd_data  (cmd_data),
    .pcm_valid (pcm_valid),
    .pcm_ready (pcm_ready),
    .pcm_neg   (pcm_neg),
    .pcm_out   (pcm_out)
  );

  always #2 CLK = ~CLK;  // 4 ns period

  // random back-pressure on the PCM port
  always @(posedge CLK) begin
    if (arst_n)
      pcm_ready <= (($random(seed) & 3) != 0);  // high about 3 cycles in 4
    else
      pcm_ready <= 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // checking

  task automatic stop_on_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp)
      stop_on_failure($sformatf("Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // bus tasks, each returns just after a rising edge

  task automatic send_cmd(input logic [15:0] word);
    int waited;
    waited = 0;
    cmd_valid <= 1'b1;
    cmd_data  <= word;
    @(negedge CLK);
    while (!cmd_ready) begin
      waited++;
      if (waited > CMD_TIMEOUT)
        stop_on_failure($sformatf("command 0x%04h was never accepted", word));
      @(negedge CLK);
    end
    @(posedge CLK);  // transfer edge
  endtask

  task automatic take_sample(output logic neg, output logic [7:0] mag);
    int waited;
    waited = 0;
    @(negedge CLK);
    while (!(pcm_valid && pcm_ready)) begin
      waited++;
      if (waited > SAMPLE_TIMEOUT)
        stop_on_failure("no PCM sample was handed over in time");
      @(negedge CLK);
    end
    neg = pcm_neg;
    mag = pcm_out;
    @(posedge CLK);
  endtask

  // earlier samples may still hold the old mix, so only the last counts
  task automatic check_exact(input int count, input logic [15:0] data);
    logic       neg;
    logic [7:0] mag;
    for (int n = 0; n < count; n++)
      take_sample(neg, mag);
    check_value("pcm_neg", 32'(neg), 32'(data[8]));
    check_value("pcm_out", 32'(mag), 32'(data[7:0]));
  endtask

  task automatic check_magnitude(input int count, input logic [15:0] data);
    logic       neg;
    logic [7:0] mag;
    int         n_pos;
    int         n_neg;
    n_pos = 0;
    n_neg = 0;
    for (int n = 0; n < count; n++) begin
      take_sample(neg, mag);
      check_value("pcm_out", 32'(mag), 32'(data[7:0]));
      if (neg)
        n_neg++;
      else
        n_pos++;
    end
    if (data[12] && (n_pos == 0 || n_neg == 0))
      stop_on_failure($sformatf("square wave showed one sign only: %0d pos, %0d neg",
                                n_pos, n_neg));
  endtask

  //////////////////////////////////////////////////////////////////////
  // trace player

  initial begin
    logic [3:0]  kind;
    logic [11:0] count;
    logic [15:0] data;
    bit          done;
    arst_n    = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    done      = 1'b0;
    $readmemh("sim/psg_trace.hex", trace_mem);
    repeat (10) @(posedge CLK);
    arst_n <= 1'b1;
    @(posedge CLK);
    for (int idx = 0; idx < TRACE_DEPTH && !done; idx++) begin
      kind  = trace_mem[idx][31:28];
      count = trace_mem[idx][27:16];
      data  = trace_mem[idx][15:0];
      if (kind != 4'h0 && cmd_valid)
        cmd_valid <= 1'b0;  // end of a command burst
      case (kind)
        4'h0: send_cmd(data);
        4'h1: check_exact(int'(count), data);
        4'h2: check_magnitude(int'(count), data);
        4'hf: done = 1'b1;
        default: stop_on_failure($sformatf("trace entry %0d has unknown kind %0h", idx, kind));
      endcase
    end
    if (!done) begin
      stop_on_failure("trace ran out without an end marker");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: sim/psg_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module psg_assertions (
  input logic       CLK,
  input logic       arst_n,
  input logic       cmd_valid,
  input logic       cmd_ready,
  input logic [15:0] cmd_data,
  input logic       pcm_valid,
  input logic       pcm_ready,
  input logic       pcm_neg,
  input logic [7:0] pcm_out
);

  //////////////////////////////////////////////////////////////////////
  // host command port

  a_cmd_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (cmd_valid && !cmd_ready) |=> $stable(cmd_data))
    else $error("cmd_data changed while the command waited for cmd_ready");

  //////////////////////////////////////////////////////////////////////
  // PCM output port

  a_pcm_hold: assert property (@(posedge CLK) disable iff (!arst_n)
    (pcm_valid && !pcm_ready) |=> (pcm_valid && $stable(pcm_out) && $stable(pcm_neg)))
    else $error("PCM sample changed or vanished before it was taken");

  a_no_neg_zero: assert property (@(posedge CLK)
    pcm_neg |-> (pcm_out != 8'd0))
    else $error("pcm_neg set on a zero magnitude");

  a_reset_quiet: assert property (@(posedge CLK)
    !arst_n |-> !pcm_valid)
    else $error("pcm_valid high during reset");

endmodule

bind psg_top psg_assertions assertions_i (
  .CLK       (CLK),
  .arst_n    (arst_n),
  .cmd_valid (cmd_valid),
  .cmd_ready (cmd_ready),
  .cmd_data  (cmd_data),
  .pcm_valid (pcm_valid),
  .pcm_ready (pcm_ready),
  .pcm_neg   (pcm_neg),
  .pcm_out   (pcm_out)
);

`default_nettype wire

// File: verilog/psg_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "psg_config.svh"

module psg_top
  import psg_pkg::*;
(
  input  logic        CLK,
  input  logic        arst_n,

  input  logic        cmd_valid,
  output logic        cmd_ready,
  input  logic [15:0] cmd_data,

  output logic        pcm_valid,
  input  logic        pcm_ready,
  output logic        pcm_neg,
  output logic [7:0]  pcm_out
);

  localparam int NV = `PSG_NUM_VOICES;

  psg_cmd_t            cmd_word;
  psg_level_t [NV-1:0] levels;  // one registered level per voice

  psg_voice_if vc_bus [NV] ();

  assign cmd_word = psg_cmd_t'(cmd_data);

  //////////////////////////////////////////////////////////////////////
  // command path

  psg_cmd_decoder decoder_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_word),
    .cmd_ready (cmd_ready),
    .vc        (vc_bus)
  );

  for (genvar i = 0; i < NV; i++) begin : g_voice
    psg_voice voice_i (
      .CLK    (CLK),
      .arst_n (arst_n),
      .vc     (vc_bus[i]),
      .level  (levels[i])
    );
  end

  //////////////////////////////////////////////////////////////////////
  // PCM output

  psg_mixer mixer_i (
    .CLK       (CLK),
    .arst_n    (arst_n),
    .levels    (levels),
    .pcm_ready (pcm_ready),
    .pcm_valid (pcm_valid),
    .pcm_neg   (pcm_neg),
    .pcm_out   (pcm_out)
  );

endmodule

`default_nettype wire

// File: verilog/psg_mixer.sv
`timescale 1ns/1ps
`default_nettype none
`include "psg_config.svh"

module psg_mixer
  import psg_pkg::*;
(
  input  logic                             CLK,
  input  logic                             arst_n,
  input  psg_level_t [`PSG_NUM_VOICES-1:0] levels,
  input  logic                             pcm_ready,
  output logic                             pcm_valid,
  output logic                             pcm_neg,
  output logic [7:0]                       pcm_out
);

  localparam int NV    = `PSG_NUM_VOICES;
  localparam int SDIV  = `PSG_SAMPLE_DIV;
  localparam int DIV_W = (SDIV > 1) ? $clog2(SDIV) : 1;
  localparam int ACC_W = $bits(psg_level_t) + ((NV > 1) ? $clog2(NV) : 0);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SDIV - 1);

  psg_mix_state_e           state;
  logic [DIV_W-1:0]         div_cnt;
  logic                     sample_tick;
  logic signed [ACC_W-1:0]  sum;
  logic                     sum_neg;
  logic [ACC_W-1:0]         mag;

  //////////////////////////////////////////////////////////////////////
  // sample rate divider

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n)
      div_cnt <= '0;
    else
      div_cnt <= (div_cnt == DIV_LAST) ? '0 : div_cnt + 1'b1;
  end

  assign sample_tick = (div_cnt == DIV_LAST);

  //////////////////////////////////////////////////////////////////////
  // signed sum, split into sign and magnitude

  always_comb begin
    sum = '0;
    for (int i = 0; i < NV; i++) begin
      sum = sum + ACC_W'($signed(levels[i]));  // sign extended
    end
  end

  assign sum_neg = sum[ACC_W-1];       // zero reads as positive
  assign mag     = sum_neg ? -sum : sum;

  //////////////////////////////////////////////////////////////////////
  // output register and handshake

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state   <= s_idle;
      pcm_out <= '0;
      pcm_neg <= 1'b0;
    end else begin
      case (state)
        s_idle: begin
          if (sample_tick) begin
            pcm_out <= 8'(mag);
            pcm_neg <= sum_neg;
            state   <= s_hold;
          end
        end
        s_hold: begin
          if (pcm_ready)
            state <= s_idle;  // ticks seen while holding are lost
        end
        default: state <= s_idle;
      endcase
    end
  end

  assign pcm_valid = (state == s_hold);

endmodule

`default_nettype wire

// File: verilog/psg_voice.sv
`timescale 1ns/1ps
`default_nettype none

module psg_voice
  import psg_pkg::*;
(
  input  logic       CLK,
  input  logic       arst_n,
  psg_voice_if.voice vc,
  output psg_level_t level
);

  logic [10:0] period_q;
  logic [10:0] count_q;   // steps left in this half-wave
  logic [3:0]  volume_q;
  logic        phase_q;   // 0 = positive half
  psg_level_t  level_pos;

  //////////////////////////////////////////////////////////////////////
  // period counter and phase

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      period_q <= '0;
      count_q  <= '0;
      phase_q  <= 1'b0;
    end else if (vc.clear) begin
      period_q <= '0;
      count_q  <= '0;
      phase_q  <= 1'b0;
    end else if (vc.load_period) begin
      period_q <= vc.period;
      count_q  <= vc.period;  // restart the half-wave
      phase_q  <= 1'b0;
    end else if (vc.step) begin
      if (period_q == '0) begin
        phase_q <= 1'b0;      // zero period holds the positive phase
      end else if (count_q == '0) begin
        count_q <= period_q;
        phase_q <= ~phase_q;
      end else begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n)
      volume_q <= '0;
    else if (vc.clear)
      volume_q <= '0;
    else if (vc.load_volume)
      volume_q <= vc.volume;
  end

  //////////////////////////////////////////////////////////////////////
  // signed output level

  assign level_pos = psg_level_t'({1'b0, volume_q});

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n)
      level <= '0;
    else if (!vc.gate)
      level <= '0;                               // gated off
    else
      level <= phase_q ? -level_pos : level_pos;
  end

endmodule

`default_nettype wire

// File: verilog/psg_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "psg_config.svh"

module psg_cmd_decoder
  import psg_pkg::*;
(
  input  logic      CLK,
  input  logic      arst_n,
  input  logic      cmd_valid,
  input  psg_cmd_t  cmd_data,
  output logic      cmd_ready,
  psg_voice_if.ctrl vc [`PSG_NUM_VOICES]
);

  localparam int NV     = `PSG_NUM_VOICES;
  localparam int TDIV   = `PSG_TICK_DIV;
  localparam int TICK_W = (TDIV > 1) ? $clog2(TDIV) : 1;
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TDIV - 1);

  psg_dec_state_e    state;
  psg_cmd_t          cmd_q;          // word being applied
  logic [NV-1:0]     voice_hit;      // one-hot of cmd_q.voice
  logic [NV-1:0]     load_period_q;
  logic [NV-1:0]     load_volume_q;
  logic [NV-1:0]     gate_q;
  logic              clear_q;
  logic              step_q;
  logic [TICK_W-1:0] tick_cnt;

  //////////////////////////////////////////////////////////////////////
  // accept / apply handshake

  assign cmd_ready = (state == s_accept);  // low for the apply cycle only

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= s_accept;
    end else begin
      case (state)
        s_accept: if (cmd_valid) state <= s_apply;
        s_apply:  state <= s_accept;
        default:  state <= s_accept;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (cmd_valid && cmd_ready)
      cmd_q <= cmd_data;
  end

  //////////////////////////////////////////////////////////////////////
  // opcode decode

  assign voice_hit = {{(NV-1){1'b0}}, 1'b1} << cmd_q.voice;

  // pulses are registered here, so a voice sees them one cycle after
  // s_apply and acts on the edge that closes them
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      load_period_q <= '0;
      load_volume_q <= '0;
      gate_q        <= '0;
      clear_q       <= 1'b0;
    end else begin
      load_period_q <= '0;
      load_volume_q <= '0;
      clear_q       <= 1'b0;
      if (state == s_apply) begin
        case (cmd_q.opcode)
          op_period:    load_period_q <= voice_hit;
          op_volume:    load_volume_q <= voice_hit;
          op_gate_on:   gate_q <= gate_q | voice_hit;
          op_gate_off:  gate_q <= gate_q & ~voice_hit;
          op_reset_all: begin
            clear_q <= 1'b1;
            gate_q  <= '0;  // clear also drops every gate
          end
          default: ;        // nop and unused codes
        endcase
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // step prescaler, free running

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      tick_cnt <= '0;
      step_q   <= 1'b0;
    end else begin
      step_q   <= (tick_cnt == TICK_LAST);
      tick_cnt <= (tick_cnt == TICK_LAST) ? '0 : tick_cnt + 1'b1;
    end
  end

  for (genvar i = 0; i < NV; i++) begin : g_bus
    assign vc[i].period      = cmd_q.value;
    assign vc[i].volume      = cmd_q.value[3:0];
    assign vc[i].load_period = load_period_q[i];
    assign vc[i].load_volume = load_volume_q[i];
    assign vc[i].gate        = gate_q[i];
    assign vc[i].clear       = clear_q;
    assign vc[i].step        = step_q;
  end

endmodule

`default_nettype wire

// File: verilog/psg_voice_if.sv
`timescale 1ns/1ps
`default_nettype none

interface psg_voice_if;

  logic [10:0] period;       // valid while load_period is high
  logic [3:0]  volume;       // valid while load_volume is high
  logic        load_period;  // one-cycle pulse
  logic        load_volume;  // one-cycle pulse
  logic        gate;         // held level
  logic        clear;        // one-cycle pulse, all voices
  logic        step;         // shared tick

  modport ctrl (
    output period, volume, load_period, load_volume, gate, clear, step
  );

  modport voice (
    input period, volume, load_period, load_volume, gate, clear, step
  );

endinterface

`default_nettype wire

// File: verilog/psg_pkg.sv
`default_nettype none

package psg_pkg;

  //////////////////////////////////////////////////////////////////////
  // host command word

  typedef enum logic [2:0] {
    op_nop       = 3'd0,
    op_period    = 3'd1,  // value[10:0] -> period
    op_volume    = 3'd2,  // value[3:0] -> volume
    op_gate_on   = 3'd3,
    op_gate_off  = 3'd4,
    op_reset_all = 3'd5   // clears every voice
  } psg_opcode_e;

  typedef struct packed {
    psg_opcode_e opcode;  // [15:13]
    logic [1:0]  voice;   // [12:11]
    logic [10:0] value;   // [10:0]
  } psg_cmd_t;

  // signed voice output, -15..+15
  typedef logic signed [4:0] psg_level_t;

  //////////////////////////////////////////////////////////////////////
  // state machines

  typedef enum logic {
    s_accept = 1'b0,
    s_apply  = 1'b1
  } psg_dec_state_e;

  typedef enum logic {
    s_idle = 1'b0,
    s_hold = 1'b1
  } psg_mix_state_e;

endpackage

`default_nettype wire

// File: verilog/psg_config.svh
`ifndef PSG_CONFIG_SVH
`define PSG_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// tone generator sizing

// voice field of a command is 2 bits, so 4 is the ceiling
`define PSG_NUM_VOICES 4

// clocks per voice step
`define PSG_TICK_DIV 4

// clocks per PCM sample
`define PSG_SAMPLE_DIV 64

`endif
